// ==== wfd_pkg.sv ====
package wfd_pkg;

  ////////////////////////////////////////////////////////////
  // defaults for the top-level parameters
  ////////////////////////////////////////////////////////////
  parameter int BUF_ADDR_W        = 10;  // 1024-word sample buffer
  parameter int HDR_FIFO_DEPTH    = 4;   // fills waiting for readout
  parameter int LONG_RESET_CYCLES = 16;  // master reset pulse length for a full reset

  // command opcode, bits 31:28 of the first frame word
  typedef enum logic [3:0] {
    OP_WR_REG  = 4'h1,  // opcode/address word, then value word
    OP_RD_REG  = 4'h2,  // reply header + value
    OP_RD_FILL = 4'h3   // reply header + one stored fill
  } cmd_op_e;

  // register map, bits 7:0 of the first frame word
  typedef enum logic [7:0] {
    REG_CHANNEL_TAG      = 8'h00,
    REG_NUM_BURSTS       = 8'h01,
    REG_INITIAL_FILL_NUM = 8'h02
  } reg_addr_e;

  // one word on any of the 32-bit streams
  typedef struct packed {
    logic [31:0] data;
    logic        last;  // final word of a frame
  } chan_word_t;

  // register file contents
  typedef struct packed {
    logic [7:0]  channel_tag;
    logic [9:0]  num_bursts;        // data words per fill
    logic [23:0] initial_fill_num;
  } chan_cfg_t;

  // one entry of the fill header FIFO
  typedef struct packed {
    logic [9:0]  start_addr;  // buffer address of the fill header word
    logic [10:0] num_words;   // header word plus data words
    logic [23:0] fill_num;
  } fill_hdr_t;

  typedef enum logic [1:0] {ACQ_IDLE, ACQ_HEADER, ACQ_DATA} acq_state_e;

  typedef enum logic [2:0] {
    CMD_IDLE, CMD_WDATA, CMD_REPLY, CMD_VALUE, CMD_FILL, CMD_DRAIN
  } cmd_state_e;

endpackage

// ==== master_reset.sv ====
`timescale 1ns/1ps

module master_reset #(
  parameter int LONG_RESET_CYCLES = wfd_pkg::LONG_RESET_CYCLES
) (
  input  logic clk125,
  input  logic rst_n,
  input  logic rst_from_master,
  output logic short_reset,  // one-cycle pulse, reloads the fill counter
  output logic long_reset    // one-cycle pulse, clears acquisition state
);

  localparam int CNT_W = $clog2(LONG_RESET_CYCLES + 1);

  logic [1:0]       line_sync;  // two-flop synchronizer
  logic             line_d;     // previous synchronized level, for the falling edge
  logic [CNT_W-1:0] high_cnt;   // high cycles, saturates at the long threshold

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      line_sync   <= '0;
      line_d      <= 1'b0;
      high_cnt    <= '0;
      short_reset <= 1'b0;
      long_reset  <= 1'b0;
    end else begin
      line_sync   <= {line_sync[0], rst_from_master};
      line_d      <= line_sync[1];
      short_reset <= 1'b0;
      long_reset  <= 1'b0;
      if (line_sync[1]) begin
        if (high_cnt != CNT_W'(LONG_RESET_CYCLES))
          high_cnt <= high_cnt + 1'b1;  // stop counting once it is long
      end else begin
        high_cnt <= '0;
        if (line_d) begin  // line just fell, classify the pulse
          if (high_cnt == CNT_W'(LONG_RESET_CYCLES))
            long_reset <= 1'b1;
          else
            short_reset <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== cmd_proc.sv ====
`timescale 1ns/1ps

module cmd_proc (
  input  logic                clk125,
  input  logic                core_rst_n,
  input  wfd_pkg::chan_word_t rx_word,
  input  logic                rx_valid,
  output logic                rx_ready,
  output wfd_pkg::chan_word_t reply_word,
  output logic                reply_valid,
  input  logic                reply_ready,
  output wfd_pkg::chan_cfg_t  cfg,
  output logic                init_fill_wr,  // initial_fill_num was just written
  input  logic                hdr_empty,
  output logic                read_start,
  input  logic                read_done,
  output logic                use_fill       // tx_mux takes the fill stream
);
  import wfd_pkg::*;

  cmd_state_e  state;
  cmd_op_e     rx_op;     // opcode field of the word on rx
  cmd_op_e     op_q;      // opcode of the frame in progress
  reg_addr_e   addr_q;
  logic        empty_q;   // fill read found no fill queued
  logic        rx_en;     // holds rx_ready off in the first cycle out of reset
  logic        rx_fire, reply_fire;
  logic [31:0] rd_value;

  assign rx_op      = cmd_op_e'(rx_word.data[31:28]);
  assign rx_ready   = rx_en && (state == CMD_IDLE || state == CMD_WDATA || state == CMD_DRAIN);
  assign rx_fire    = rx_valid && rx_ready;
  assign reply_fire = reply_valid && reply_ready;

  // register readback, unmapped addresses read zero
  always_comb begin
    case (addr_q)
      REG_CHANNEL_TAG:      rd_value = {24'd0, cfg.channel_tag};
      REG_NUM_BURSTS:       rd_value = {22'd0, cfg.num_bursts};
      REG_INITIAL_FILL_NUM: rd_value = {8'd0, cfg.initial_fill_num};
      default:              rd_value = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // reply words, held by the state until accepted
  ////////////////////////////////////////////////////////////
  always_comb begin
    reply_word  = '0;
    reply_valid = 1'b0;
    case (state)
      CMD_REPLY: begin
        reply_valid     = 1'b1;
        reply_word.data = {op_q, 19'd0, empty_q, addr_q};  // header word
        // write and empty fill read end here, other replies continue
        reply_word.last = (op_q == OP_WR_REG) || (op_q == OP_RD_FILL && empty_q);
      end
      CMD_VALUE: begin
        reply_valid     = 1'b1;
        reply_word.data = rd_value;
        reply_word.last = 1'b1;
      end
      default: ;
    endcase
  end

  // frame fields, latched on the first word
  always_ff @(posedge clk125) begin
    if (state == CMD_IDLE && rx_fire) begin
      op_q    <= rx_op;
      addr_q  <= reg_addr_e'(rx_word.data[7:0]);
      empty_q <= (rx_op == OP_RD_FILL) && hdr_empty;  // only reads pop, so it stays valid
    end
  end

  ////////////////////////////////////////////////////////////
  // frame sequencer and register file
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk125) begin
    if (!core_rst_n) begin
      state        <= CMD_IDLE;
      rx_en        <= 1'b0;
      cfg          <= '0;
      init_fill_wr <= 1'b0;
      read_start   <= 1'b0;
      use_fill     <= 1'b0;
    end else begin
      rx_en        <= 1'b1;
      init_fill_wr <= 1'b0;
      read_start   <= 1'b0;
      case (state)
        CMD_IDLE: if (rx_fire) begin
          case (rx_op)
            OP_WR_REG:             state <= CMD_WDATA;
            OP_RD_REG, OP_RD_FILL: state <= CMD_REPLY;
            default:               state <= rx_word.last ? CMD_IDLE : CMD_DRAIN;  // unknown op
          endcase
        end
        CMD_WDATA: if (rx_fire) begin
          case (addr_q)
            REG_CHANNEL_TAG: cfg.channel_tag <= rx_word.data[7:0];
            REG_NUM_BURSTS:  cfg.num_bursts  <= rx_word.data[9:0];
            REG_INITIAL_FILL_NUM: begin
              cfg.initial_fill_num <= rx_word.data[23:0];
              init_fill_wr         <= 1'b1;  // acq_ctrl reloads its counter
            end
            default: ;  // write to an unmapped address is dropped
          endcase
          state <= CMD_REPLY;
        end
        CMD_DRAIN: if (rx_fire && rx_word.last) state <= CMD_IDLE;
        CMD_REPLY: if (reply_fire) begin
          if (op_q == OP_RD_REG) begin
            state <= CMD_VALUE;
          end else if (op_q == OP_RD_FILL && !empty_q) begin
            state      <= CMD_FILL;
            read_start <= 1'b1;  // pop the header and start streaming
            use_fill   <= 1'b1;  // hand the output over
          end else begin
            state <= CMD_IDLE;
          end
        end
        CMD_VALUE: if (reply_fire) state <= CMD_IDLE;
        CMD_FILL: if (read_done) begin  // last fill word accepted
          use_fill <= 1'b0;
          state    <= CMD_IDLE;
        end
        default: state <= CMD_IDLE;
      endcase
    end
  end

endmodule

// ==== acq_ctrl.sv ====
`timescale 1ns/1ps

module acq_ctrl (
  input  logic               clk125,
  input  logic               core_rst_n,
  input  logic               short_reset,
  input  logic               acq_trig,
  input  logic               acq_enable,
  input  logic [11:0]        adc_sample,
  input  logic               adc_ovr,
  input  wfd_pkg::chan_cfg_t cfg,
  input  logic               init_fill_wr,
  input  logic [10:0]        free_words,
  input  logic               hdr_full,
  output logic               wr_en,
  output logic [31:0]        wr_word,
  output logic               hdr_push,
  output wfd_pkg::fill_hdr_t hdr_in,  // entry of the fill being captured
  output logic               acq_done
);
  import wfd_pkg::*;

  acq_state_e  state;
  logic [2:0]  trig_sr;    // two sync stages plus one for the edge
  logic        trig_rise;
  logic        room;       // buffer and header FIFO can take one more fill
  logic        start;
  logic        last_wr;    // final buffer write of the fill
  logic [23:0] fill_cnt;
  logic [9:0]  next_addr;  // follows the buffer write pointer
  logic [9:0]  dcnt;       // data word index

  assign trig_rise = trig_sr[1] & ~trig_sr[2];
  assign room      = (free_words >= {1'b0, cfg.num_bursts} + 11'd1) && !hdr_full;
  assign start     = (state == ACQ_IDLE) && trig_rise && acq_enable && room;
  assign last_wr   = (state == ACQ_HEADER && hdr_in.num_words == 11'd1) ||
                     (state == ACQ_DATA && {1'b0, dcnt} == hdr_in.num_words - 11'd2);

  // buffer writes: fill header word, then one formatted sample per cycle
  assign wr_en = (state != ACQ_IDLE);
  always_comb begin
    if (state == ACQ_HEADER)
      wr_word = {cfg.channel_tag, hdr_in.fill_num};
    else
      wr_word = {6'd0, dcnt, adc_ovr, 3'd0, adc_sample};  // index, over-range, sample
  end

  always_ff @(posedge clk125) begin
    if (!core_rst_n) begin
      trig_sr   <= '0;
      state     <= ACQ_IDLE;
      fill_cnt  <= '0;
      next_addr <= '0;
      acq_done  <= 1'b0;
      hdr_push  <= 1'b0;
    end else begin
      trig_sr  <= {trig_sr[1:0], acq_trig};
      acq_done <= 1'b0;
      hdr_push <= 1'b0;
      case (state)
        ACQ_IDLE:   if (start) state <= ACQ_HEADER;  // busy or full triggers are dropped
        ACQ_HEADER: state <= last_wr ? ACQ_IDLE : ACQ_DATA;
        ACQ_DATA:   if (last_wr) state <= ACQ_IDLE;
        default:    state <= ACQ_IDLE;
      endcase
      if (last_wr) begin
        acq_done  <= 1'b1;  // cycle after the last write
        hdr_push  <= 1'b1;
        next_addr <= next_addr + hdr_in.num_words[9:0];  // wraps with the buffer
      end
      if (init_fill_wr || short_reset)
        fill_cnt <= cfg.initial_fill_num;
      else if (last_wr)
        fill_cnt <= fill_cnt + 1'b1;
    end
  end

  // fill entry and data index
  always_ff @(posedge clk125) begin
    if (start) begin
      hdr_in.start_addr <= next_addr;
      hdr_in.num_words  <= {1'b0, cfg.num_bursts} + 11'd1;  // plus the header word
      hdr_in.fill_num   <= fill_cnt;
    end
    if (state == ACQ_DATA) dcnt <= dcnt + 1'b1;
    else dcnt <= '0;
  end

endmodule

// ==== fill_buffer.sv ====
`timescale 1ns/1ps

module fill_buffer #(
  parameter int BUF_ADDR_W     = wfd_pkg::BUF_ADDR_W,
  parameter int HDR_FIFO_DEPTH = wfd_pkg::HDR_FIFO_DEPTH
) (
  input  logic                clk125,
  input  logic                core_rst_n,
  input  logic                wr_en,
  input  logic [31:0]         wr_word,
  input  logic                hdr_push,
  input  wfd_pkg::fill_hdr_t  hdr_in,
  output logic [BUF_ADDR_W:0] free_words,
  output logic                hdr_full,
  output logic                hdr_empty,
  input  logic                read_start,
  output wfd_pkg::chan_word_t fill_word,
  output logic                fill_valid,
  input  logic                fill_ready,
  output logic                read_done
);
  import wfd_pkg::*;

  localparam int HP_W = $clog2(HDR_FIFO_DEPTH);

  logic [31:0]           mem [2**BUF_ADDR_W];  // circular sample memory
  logic [BUF_ADDR_W-1:0] wr_ptr, rd_addr;
  logic [BUF_ADDR_W:0]   rd_left;              // words of the fill not yet read
  logic [BUF_ADDR_W:0]   cur_words;            // size of the fill being read
  fill_hdr_t             hdr_mem [HDR_FIFO_DEPTH];
  logic [HP_W-1:0]       hdr_wp, hdr_rp;
  logic [HP_W:0]         hdr_cnt;
  logic                  push, pop, load;

  assign hdr_full  = (hdr_cnt == (HP_W + 1)'(HDR_FIFO_DEPTH));
  assign hdr_empty = (hdr_cnt == '0);
  assign push      = hdr_push && !hdr_full;
  assign pop       = read_start && !hdr_empty;
  assign load      = (rd_left != '0) && (!fill_valid || fill_ready);  // prefetch next word
  assign read_done = fill_valid && fill_ready && fill_word.last;

  ////////////////////////////////////////////////////////////
  // pointers, counts and output valid
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk125) begin
    if (!core_rst_n) begin
      wr_ptr     <= '0;
      free_words <= (BUF_ADDR_W + 1)'(2**BUF_ADDR_W);
      hdr_wp     <= '0;
      hdr_rp     <= '0;
      hdr_cnt    <= '0;
      rd_left    <= '0;
      fill_valid <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // wraps at the buffer end
      // one word used per write, whole fill released after readout
      free_words <= free_words - (BUF_ADDR_W + 1)'(wr_en) + (read_done ? cur_words : '0);
      if (push) hdr_wp <= (hdr_wp == HP_W'(HDR_FIFO_DEPTH - 1)) ? '0 : hdr_wp + 1'b1;
      if (pop) hdr_rp <= (hdr_rp == HP_W'(HDR_FIFO_DEPTH - 1)) ? '0 : hdr_rp + 1'b1;
      hdr_cnt <= hdr_cnt + (HP_W + 1)'(push) - (HP_W + 1)'(pop);
      if (pop) rd_left <= hdr_mem[hdr_rp].num_words;
      else if (load) rd_left <= rd_left - 1'b1;
      if (load) fill_valid <= 1'b1;
      else if (fill_ready) fill_valid <= 1'b0;
    end
  end

  // memories, read address and output word
  always_ff @(posedge clk125) begin
    if (wr_en) mem[wr_ptr] <= wr_word;
    if (push) hdr_mem[hdr_wp] <= hdr_in;
    if (pop) begin
      rd_addr   <= hdr_mem[hdr_rp].start_addr;
      cur_words <= hdr_mem[hdr_rp].num_words;
    end else if (load) begin
      rd_addr <= rd_addr + 1'b1;
    end
    if (load) begin
      fill_word.data <= mem[rd_addr];         // one cycle of read latency
      fill_word.last <= (rd_left == 'd1);     // final data word of the fill
    end
  end

endmodule

// ==== tx_mux.sv ====
`timescale 1ns/1ps

module tx_mux (
  input  logic                clk125,
  input  logic                core_rst_n,
  input  logic                readout_pause,
  input  logic                use_fill,     // fill stream selected
  input  wfd_pkg::chan_word_t reply_word,
  input  logic                reply_valid,
  output logic                reply_ready,
  input  wfd_pkg::chan_word_t fill_word,
  input  logic                fill_valid,
  output logic                fill_ready,
  output wfd_pkg::chan_word_t tx_word,
  output logic                tx_valid,
  input  logic                tx_ready
);

  logic [1:0] pause_sync;  // two-flop synchronizer
  logic       paused;
  logic       go;          // output may move a word

  always_ff @(posedge clk125) begin
    if (!core_rst_n) pause_sync <= '0;
    else pause_sync <= {pause_sync[0], readout_pause};
  end

  assign paused = pause_sync[1];
  assign go     = tx_ready && !paused;

  // only the selected source sees ready, nothing moves while paused
  assign tx_word     = use_fill ? fill_word : reply_word;
  assign tx_valid    = (use_fill ? fill_valid : reply_valid) && !paused;
  assign fill_ready  = use_fill && go;
  assign reply_ready = !use_fill && go;

endmodule

// ==== chan_top.sv ====
`timescale 1ns/1ps

module chan_top #(
  parameter int BUF_ADDR_W        = wfd_pkg::BUF_ADDR_W,
  parameter int HDR_FIFO_DEPTH    = wfd_pkg::HDR_FIFO_DEPTH,
  parameter int LONG_RESET_CYCLES = wfd_pkg::LONG_RESET_CYCLES
) (
  input  logic               clk125,
  input  logic               rst_n,
  input  logic               acq_trig,         // async level from the master
  input  logic               acq_enable,
  input  logic               readout_pause,    // async level from the master
  input  logic               rst_from_master,  // pulse length selects short or long reset
  input  logic [11:0]        adc_sample,
  input  logic               adc_ovr,
  input  wfd_pkg::chan_word_t rx_word,
  input  logic               rx_valid,
  output logic               rx_ready,
  output wfd_pkg::chan_word_t tx_word,
  output logic               tx_valid,
  input  logic               tx_ready,
  output logic               acq_done
);
  import wfd_pkg::*;

  logic        short_reset, long_reset;
  logic        core_rst_n;          // board reset or long reset from the master
  chan_word_t  reply_word, fill_word;
  logic        reply_valid, reply_ready;
  logic        fill_valid, fill_ready;
  chan_cfg_t   cfg;
  logic        init_fill_wr;
  logic        hdr_empty, hdr_full, hdr_push;
  logic        read_start, read_done, use_fill;
  logic        wr_en;
  logic [31:0] wr_word;
  fill_hdr_t   hdr_in;
  logic [BUF_ADDR_W:0] free_words;

  assign core_rst_n = rst_n & ~long_reset;  // long reset clears all acquisition state

  ////////////////////////////////////////////////////////////
  // master reset, command side
  ////////////////////////////////////////////////////////////
  master_reset #(.LONG_RESET_CYCLES(LONG_RESET_CYCLES)) u_master_reset (
    .clk125, .rst_n, .rst_from_master, .short_reset, .long_reset
  );

  cmd_proc u_cmd_proc (
    .clk125, .core_rst_n, .rx_word, .rx_valid, .rx_ready,
    .reply_word, .reply_valid, .reply_ready,
    .cfg, .init_fill_wr, .hdr_empty, .read_start, .read_done, .use_fill
  );

  ////////////////////////////////////////////////////////////
  // capture, storage and output
  ////////////////////////////////////////////////////////////
  acq_ctrl u_acq_ctrl (
    .clk125, .core_rst_n, .short_reset, .acq_trig, .acq_enable,
    .adc_sample, .adc_ovr, .cfg, .init_fill_wr, .free_words, .hdr_full,
    .wr_en, .wr_word, .hdr_push, .hdr_in, .acq_done
  );

  fill_buffer #(
    .BUF_ADDR_W    (BUF_ADDR_W),
    .HDR_FIFO_DEPTH(HDR_FIFO_DEPTH)
  ) u_fill_buffer (
    .clk125, .core_rst_n, .wr_en, .wr_word, .hdr_push, .hdr_in,
    .free_words, .hdr_full, .hdr_empty, .read_start,
    .fill_word, .fill_valid, .fill_ready, .read_done
  );

  tx_mux u_tx_mux (
    .clk125, .core_rst_n, .readout_pause, .use_fill,
    .reply_word, .reply_valid, .reply_ready,
    .fill_word, .fill_valid, .fill_ready,
    .tx_word, .tx_valid, .tx_ready
  );

endmodule

// ==== chan_top_asserts.sv ====
`timescale 1ns/1ps

module chan_top_asserts (
  input logic                clk125,
  input logic                rst_n,
  input logic                acq_done,
  input wfd_pkg::chan_word_t tx_word,
  input logic                tx_valid,
  input logic                tx_ready,
  input logic                readout_pause,  // raw level, before the tx_mux synchronizer
  input logic                short_reset,
  input logic                long_reset
);

  int unsigned fail_count = 0;  // number of failed checks so far

  ////////////////////////////////////////////////////////////
  // capture and reset pulses
  ////////////////////////////////////////////////////////////
  a_done_pulse: assert property (
    @(posedge clk125) disable iff (!rst_n) acq_done |=> !acq_done
  ) else begin
    $error("acq_done stayed high for more than one cycle");
    fail_count++;
  end

  a_reset_kind: assert property (
    @(posedge clk125) disable iff (!rst_n) !(short_reset && long_reset)
  ) else begin
    $error("short_reset and long_reset high in the same cycle");
    fail_count++;
  end

  ////////////////////////////////////////////////////////////
  // output stream
  ////////////////////////////////////////////////////////////
  a_tx_hold: assert property (
    @(posedge clk125) disable iff (!rst_n) tx_valid && !tx_ready |=> $stable(tx_word)
  ) else begin
    $error("tx_word changed while stalled");
    fail_count++;
  end

  // two sync stages, so the third high sample sees the output gated
  a_pause_gate: assert property (
    @(posedge clk125) disable iff (!rst_n)
      readout_pause && $past(readout_pause) && $past(readout_pause, 2) |-> !tx_valid
  ) else begin
    $error("tx_valid high two cycles into a readout pause");
    fail_count++;
  end

endmodule

bind chan_top chan_top_asserts u_asserts (.*);

// ==== tb_chan_top.sv ====
`timescale 1ns/1ps

module tb_chan_top;
  import wfd_pkg::*;

  localparam int TIMEOUT = 2000;  // cycles allowed per wait loop

  logic        clk125 = 1'b0;
  logic        rst_n, acq_trig, acq_enable, readout_pause, rst_from_master;
  logic [11:0] adc_sample;
  logic        adc_ovr;
  chan_word_t  rx_word, tx_word;
  logic        rx_valid, rx_ready, tx_valid, tx_ready, acq_done;

  logic [31:0] lcg_state = 32'h9d9c1211;
  logic [31:0] exp_q[$];       // expected words of the frame in flight
  logic [23:0] fill_num_q[$];  // model of the header FIFO
  logic [12:0] fill_smp_q[$];  // {ovr, sample} held during each queued fill
  logic [7:0]  tag_val;
  logic [9:0]  nb_val;
  logic [23:0] init_val, next_fill;

  chan_top i_dut (.*);

  always #4 clk125 = ~clk125;  // 125 MHz

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // reply header: opcode, empty flag, address
  function automatic logic [31:0] reply_hdr(cmd_op_e op, logic empty, logic [7:0] addr);
    return {op, 19'd0, empty, addr};
  endfunction

  task automatic stop_on_failure();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic value_error(string what, logic [31:0] got, logic [31:0] want);
    $display("** Error at %0t: %s, got %h, expected %h", $time, what, got, want);
    stop_on_failure();
  endtask

  task automatic timed_out(string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    stop_on_failure();
  endtask

  // one clock, inputs change 1 ns after the edge
  task automatic step();
    @(posedge clk125);
    #1;
    if (i_dut.u_asserts.fail_count != 0) begin
      $display("bound protocol assertion failed at %0t", $time);
      stop_on_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // command driver and output checker
  ////////////////////////////////////////////////////////////
  task automatic send_word(logic [31:0] data, logic last);
    int n;
    rx_word.data = data;
    rx_word.last = last;
    rx_valid     = 1'b1;
    n = 0;
    while (!rx_ready) begin
      step();
      n++;
      if (n > TIMEOUT) timed_out("rx_ready");
    end
    step();  // word taken at this edge
    rx_valid = 1'b0;
  endtask

  task automatic check_frame(bit rand_ready, bit pause);
    int n, cyc;
    logic [31:0] rnd, want;
    n   = 0;
    cyc = 0;
    while (exp_q.size() != 0) begin
      rnd           = lcg_next();
      tx_ready      = rand_ready ? rnd[9] : 1'b1;
      readout_pause = pause && cyc >= 6 && cyc < 20;  // pause window
      if (tx_valid && tx_ready) begin
        want = exp_q.pop_front();
        assert (tx_word.data == want) else value_error("tx_word.data", tx_word.data, want);
        assert (tx_word.last == (exp_q.size() == 0))
          else value_error("tx_word.last", 32'(tx_word.last), 32'(exp_q.size() == 0));
        n = 0;
      end
      step();
      n++;
      cyc++;
      if (n > TIMEOUT) timed_out("a word on tx");
    end
    tx_ready      = 1'b0;
    readout_pause = 1'b0;
  endtask

  task automatic write_reg(logic [7:0] addr, logic [31:0] value);
    send_word({OP_WR_REG, 20'd0, addr}, 1'b0);
    send_word(value, 1'b1);
    exp_q.push_back(reply_hdr(OP_WR_REG, 1'b0, addr));
    check_frame(1'b0, 1'b0);
  endtask

  task automatic read_reg(logic [7:0] addr, logic [31:0] value);
    send_word({OP_RD_REG, 20'd0, addr}, 1'b1);
    exp_q.push_back(reply_hdr(OP_RD_REG, 1'b0, addr));
    exp_q.push_back(value);
    check_frame(1'b0, 1'b0);
  endtask

  // empty reply, or header + fill header + num_bursts data words
  task automatic read_fill(bit rand_ready, bit pause);
    logic [12:0] smp;
    send_word({OP_RD_FILL, 28'd0}, 1'b1);
    if (fill_num_q.size() == 0) begin
      exp_q.push_back(reply_hdr(OP_RD_FILL, 1'b1, 8'h00));
    end else begin
      smp = fill_smp_q.pop_front();
      exp_q.push_back(reply_hdr(OP_RD_FILL, 1'b0, 8'h00));
      exp_q.push_back({tag_val, fill_num_q.pop_front()});
      for (int i = 0; i < nb_val; i++)
        exp_q.push_back({i[15:0], smp[12], 3'd0, smp[11:0]});  // index, ovr, sample
    end
    check_frame(rand_ready, pause);
  endtask

  task automatic capture_fill(logic [11:0] sample, logic ovr);
    int n;
    adc_sample = sample;  // constant for the whole fill
    adc_ovr    = ovr;
    acq_trig   = 1'b1;
    n = 0;
    while (!acq_done) begin
      step();
      n++;
      if (n > TIMEOUT) timed_out("acq_done after a trigger");
    end
    acq_trig = 1'b0;
    fill_num_q.push_back(next_fill);
    fill_smp_q.push_back({ovr, sample});
    next_fill = next_fill + 1'b1;
    repeat (4) step();  // synchronizer sees the trigger low again
  endtask

  task automatic pulse_master_reset(int cycles);
    rst_from_master = 1'b1;
    repeat (cycles) step();
    rst_from_master = 1'b0;
    repeat (8) step();  // sync, classify, reset done
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rst_n           = 1'b0;
    acq_trig        = 1'b0;
    acq_enable      = 1'b0;
    readout_pause   = 1'b0;
    rst_from_master = 1'b0;
    adc_sample      = '0;
    adc_ovr         = 1'b0;
    rx_word         = '0;
    rx_valid        = 1'b0;
    tx_ready        = 1'b0;
    repeat (8) step();
    rst_n = 1'b1;
    // first cycle out of reset, outputs still quiet
    assert (!rx_ready) else value_error("rx_ready after reset", 32'(rx_ready), 0);
    assert (!tx_valid) else value_error("tx_valid after reset", 32'(tx_valid), 0);
    assert (!acq_done) else value_error("acq_done after reset", 32'(acq_done), 0);

    // register write, readback, unmapped address, unknown opcode
    tag_val  = 8'h5a;
    nb_val   = 10'd12;
    init_val = 24'h001234;
    write_reg(REG_CHANNEL_TAG, {24'd0, tag_val});
    write_reg(REG_NUM_BURSTS, {22'd0, nb_val});
    write_reg(REG_INITIAL_FILL_NUM, {8'd0, init_val});
    next_fill = init_val;
    read_reg(REG_CHANNEL_TAG, {24'd0, tag_val});
    read_reg(REG_NUM_BURSTS, {22'd0, nb_val});
    read_reg(REG_INITIAL_FILL_NUM, {8'd0, init_val});
    read_reg(8'h7f, 32'd0);
    send_word(32'hf000_0000, 1'b1);  // dropped without a reply
    read_reg(REG_NUM_BURSTS, {22'd0, nb_val});

    // one fill captured and read back
    acq_enable = 1'b1;
    capture_fill(12'ha5c, 1'b1);
    read_fill(1'b0, 1'b0);

    // consecutive numbers across the 24-bit wrap, then short reset
    init_val = 24'hfffffe;
    write_reg(REG_INITIAL_FILL_NUM, {8'd0, init_val});
    next_fill = init_val;
    capture_fill(12'h001, 1'b0);
    capture_fill(12'h7ff, 1'b1);
    capture_fill(12'hfff, 1'b0);
    repeat (3) read_fill(1'b0, 1'b0);
    pulse_master_reset(4);
    next_fill = init_val;
    capture_fill(12'h3c3, 1'b0);
    read_fill(1'b0, 1'b0);

    // trigger while disabled, then an empty read
    acq_enable = 1'b0;
    acq_trig   = 1'b1;
    repeat (nb_val + 20) begin
      step();
      assert (!acq_done) else value_error("acq_done with acq_enable low", 32'(acq_done), 0);
    end
    acq_trig = 1'b0;
    repeat (4) step();
    read_fill(1'b0, 1'b0);
    acq_enable = 1'b1;

    // longer fill under random tx_ready and a pause window
    nb_val = 10'd40;
    write_reg(REG_NUM_BURSTS, {22'd0, nb_val});
    capture_fill(12'h5a5, 1'b1);
    read_fill(1'b1, 1'b1);

    // long reset drops the queued fill
    capture_fill(12'h0f0, 1'b0);
    pulse_master_reset(LONG_RESET_CYCLES + 4);
    fill_num_q.delete();
    fill_smp_q.delete();
    read_fill(1'b0, 1'b0);

    if (i_dut.u_asserts.fail_count != 0) begin
      $display("bound protocol assertion failed before the end of the run");
      stop_on_failure();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== chan_top.f ====
wfd_pkg.sv
master_reset.sv
cmd_proc.sv
acq_ctrl.sv
fill_buffer.sv
tx_mux.sv
chan_top.sv
chan_top_asserts.sv
tb_chan_top.sv

// ==== Bender.yml ====
package:
  name: chan_top

sources:
  - wfd_pkg.sv
  - master_reset.sv
  - cmd_proc.sv
  - acq_ctrl.sv
  - fill_buffer.sv
  - tx_mux.sv
  - chan_top.sv
  - target: test
    files:
      - chan_top_asserts.sv
      - tb_chan_top.sv
